// ==== src/gbe_loopback_settings.svh ====
`ifndef GBE_LOOPBACK_SETTINGS_SVH
`define GBE_LOOPBACK_SETTINGS_SVH

`default_nettype none

// byte buffer holds more than one maximum-size ethernet frame
`define GBE_BYTE_DEPTH 2048

// frames that can wait for transmit behind the one being sent
`define GBE_DESC_DEPTH 4

// frame length count
`define GBE_LEN_W 12

// saturating drop counter
`define GBE_DROP_W 16

`default_nettype wire

`endif

// ==== src/gbe_loopback_pkg.sv ====
`include "gbe_loopback_settings.svh"

`default_nettype none

package gbe_loopback_pkg;

  // one byte of the mac byte stream
  typedef logic [7:0] mac_byte_t;

  // one stored frame, written after its last byte
  typedef struct packed {
    // bytes actually held in the byte buffer
    logic [`GBE_LEN_W-1:0] len;
    // mac goodframe and nothing lost to a full buffer
    logic                  good;
  } frame_desc_t;

endpackage

`default_nettype wire

// ==== src/frame_fifo.sv ====
`default_nettype none

module frame_fifo #(
  parameter type payload_t = logic [7:0],
  parameter int  DEPTH     = 4
) (
  input  wire      clk_125,
  input  wire      arst_n_i,
  input  wire      push_i,
  input  payload_t push_data_i,
  output logic     full_o,
  input  wire      pop_i,
  output payload_t head_o,
  output logic     empty_o
);

  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int CNT_W  = $clog2(DEPTH + 1);

  payload_t          mem [DEPTH];
  logic [ADDR_W-1:0] wr_ptr_q;
  logic [ADDR_W-1:0] rd_ptr_q;
  logic [CNT_W-1:0]  count_q;
  logic              do_push;
  logic              do_pop;

  // pointers wrap at DEPTH, which need not be a power of two
  function automatic logic [ADDR_W-1:0] next_ptr(input logic [ADDR_W-1:0] ptr);
    if (ptr == ADDR_W'(DEPTH - 1)) begin
      return '0;
    end
    return ptr + 1'b1;
  endfunction

  assign full_o  = (count_q == CNT_W'(DEPTH));
  assign empty_o = (count_q == '0);
  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // first word falls through
  assign head_o = mem[rd_ptr_q];

  always_ff @(posedge clk_125) begin
    if (do_push) begin
      mem[wr_ptr_q] <= push_data_i;
    end
  end

  always_ff @(posedge clk_125 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) begin
        wr_ptr_q <= next_ptr(wr_ptr_q);
      end
      if (do_pop) begin
        rd_ptr_q <= next_ptr(rd_ptr_q);
      end
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/rx_frame_writer.sv ====
`include "gbe_loopback_settings.svh"

`default_nettype none

module rx_frame_writer (
  input  wire                         clk_125,
  input  wire                         arst_n_i,
  input  gbe_loopback_pkg::mac_byte_t rx_data_i,
  input  wire                         rx_dvld_i,
  input  wire                         rx_goodframe_i,
  input  wire                         rx_badframe_i,
  input  wire                         byte_full_i,
  output logic                        byte_push_o,
  output gbe_loopback_pkg::mac_byte_t byte_data_o,
  input  wire                         desc_full_i,
  output logic                        desc_push_o,
  output gbe_loopback_pkg::frame_desc_t desc_data_o,
  output logic [`GBE_DROP_W-1:0]      drop_count_o
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_RECV,
    S_WAIT
  } state_t;

  state_t                      state_q;
  gbe_loopback_pkg::mac_byte_t pend_data_q;
  logic                        pend_q;
  logic                        first_q;
  logic                        ign_q;
  logic                        trunc_q;
  logic                        good_q;
  logic                        desc_push_q;
  logic [`GBE_LEN_W-1:0]       cnt_q;
  logic [`GBE_DROP_W-1:0]      drop_q;
  logic                        status;
  logic                        drop_start;
  logic                        ign_c;
  logic                        lost;
  logic                        desc_good;
  logic                        drop_end;
  logic [`GBE_DROP_W:0]        drop_sum;

  assign status = rx_goodframe_i || rx_badframe_i;

  // keep-or-ignore is decided as the first byte is pushed, one cycle after
  // dvld rises; by then any descriptor of the previous frame is counted in desc_full_i
  assign drop_start = pend_q && first_q && desc_full_i;
  assign ign_c      = ign_q || drop_start;

  assign byte_push_o = pend_q && !ign_c && !byte_full_i;
  assign byte_data_o = pend_data_q;
  assign lost        = pend_q && !ign_c && byte_full_i;

  assign desc_good = good_q && !trunc_q;
  assign drop_end  = desc_push_q && !desc_good;

  assign desc_push_o = desc_push_q;

  always_comb begin
    desc_data_o.len  = cnt_q;
    desc_data_o.good = desc_good;
  end

  // ignored start and bad descriptor can land in the same cycle
  assign drop_sum = {1'b0, drop_q}
                  + (`GBE_DROP_W + 1)'(drop_start)
                  + (`GBE_DROP_W + 1)'(drop_end);

  assign drop_count_o = drop_q;

  always_ff @(posedge clk_125) begin
    pend_data_q <= rx_data_i;
  end

  always_ff @(posedge clk_125 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q     <= S_IDLE;
      pend_q      <= 1'b0;
      first_q     <= 1'b0;
      ign_q       <= 1'b0;
      trunc_q     <= 1'b0;
      good_q      <= 1'b0;
      desc_push_q <= 1'b0;
      cnt_q       <= '0;
      drop_q      <= '0;
    end else begin
      pend_q      <= rx_dvld_i;
      first_q     <= rx_dvld_i && (state_q == S_IDLE);
      desc_push_q <= 1'b0;
      drop_q      <= drop_sum[`GBE_DROP_W] ? '1 : drop_sum[`GBE_DROP_W-1:0];

      if (byte_push_o) begin
        cnt_q <= cnt_q + 1'b1;
      end
      if (lost) begin
        trunc_q <= 1'b1;
      end
      if (drop_start) begin
        ign_q <= 1'b1;
      end

      case (state_q)
        S_IDLE: begin
          if (rx_dvld_i) begin
            state_q <= S_RECV;
            cnt_q   <= '0;
            trunc_q <= 1'b0;
            ign_q   <= 1'b0;
          end
        end
        S_RECV: begin
          // status may come in the same cycle that dvld falls
          if (!rx_dvld_i) begin
            if (status) begin
              state_q     <= S_IDLE;
              good_q      <= rx_goodframe_i;
              desc_push_q <= !ign_c;
            end else begin
              state_q <= S_WAIT;
            end
          end
        end
        default: begin
          if (status) begin
            state_q     <= S_IDLE;
            good_q      <= rx_goodframe_i;
            desc_push_q <= !ign_c;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/tx_frame_reader.sv ====
`include "gbe_loopback_settings.svh"

`default_nettype none

module tx_frame_reader (
  input  wire                           clk_125,
  input  wire                           arst_n_i,
  input  wire                           desc_empty_i,
  input  gbe_loopback_pkg::frame_desc_t desc_head_i,
  output logic                          desc_pop_o,
  input  wire                           byte_empty_i,
  input  gbe_loopback_pkg::mac_byte_t   byte_head_i,
  output logic                          byte_pop_o,
  output gbe_loopback_pkg::mac_byte_t   tx_data_o,
  output logic                          tx_dvld_o,
  input  wire                           tx_ack_i
);

  typedef enum logic [1:0] {
    S_IDLE,
    S_WAIT_ACK,
    S_SEND,
    S_DRAIN
  } state_t;

  state_t                state_q;
  logic [`GBE_LEN_W-1:0] rem_q;
  logic                  want_byte;
  logic                  last_byte;

  // a descriptor is only at the head once all of its bytes are stored
  assign desc_pop_o = (state_q == S_IDLE) && !desc_empty_i;

  always_comb begin
    case (state_q)
      S_WAIT_ACK: want_byte = tx_ack_i;
      S_SEND:     want_byte = 1'b1;
      S_DRAIN:    want_byte = 1'b1;
      default:    want_byte = 1'b0;
    endcase
  end

  assign byte_pop_o = want_byte && !byte_empty_i;
  assign last_byte  = byte_pop_o && (rem_q == `GBE_LEN_W'(1));

  // the head byte stays put until the ack pops it
  assign tx_data_o = byte_head_i;
  assign tx_dvld_o = (state_q == S_WAIT_ACK) || (state_q == S_SEND);

  always_ff @(posedge clk_125 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      state_q <= S_IDLE;
      rem_q   <= '0;
    end else begin
      if (byte_pop_o) begin
        rem_q <= rem_q - 1'b1;
      end

      case (state_q)
        S_IDLE: begin
          if (desc_pop_o) begin
            rem_q <= desc_head_i.len;
            // zero-length frames are consumed here and skipped
            if (desc_head_i.len != '0) begin
              state_q <= desc_head_i.good ? S_WAIT_ACK : S_DRAIN;
            end
          end
        end
        S_WAIT_ACK: begin
          if (byte_pop_o) begin
            state_q <= last_byte ? S_IDLE : S_SEND;
          end
        end
        default: begin
          // send and drain both end on the last byte
          if (last_byte) begin
            state_q <= S_IDLE;
          end
        end
      endcase
    end
  end

endmodule

`default_nettype wire

// ==== src/gbe_loopback.sv ====
`include "gbe_loopback_settings.svh"

`default_nettype none

module gbe_loopback (
  input  wire                         clk_125,
  input  wire                         arst_n_i,
  input  gbe_loopback_pkg::mac_byte_t rx_data_i,
  input  wire                         rx_dvld_i,
  input  wire                         rx_goodframe_i,
  input  wire                         rx_badframe_i,
  output gbe_loopback_pkg::mac_byte_t tx_data_o,
  output logic                        tx_dvld_o,
  input  wire                         tx_ack_i,
  output logic [`GBE_DROP_W-1:0]      drop_count_o
);

  logic                          byte_push;
  gbe_loopback_pkg::mac_byte_t   byte_data;
  logic                          byte_full;
  logic                          byte_pop;
  gbe_loopback_pkg::mac_byte_t   byte_head;
  logic                          byte_empty;
  logic                          desc_push;
  gbe_loopback_pkg::frame_desc_t desc_data;
  logic                          desc_full;
  logic                          desc_pop;
  gbe_loopback_pkg::frame_desc_t desc_head;
  logic                          desc_empty;

  rx_frame_writer u_writer (
    .clk_125        (clk_125),
    .arst_n_i       (arst_n_i),
    .rx_data_i      (rx_data_i),
    .rx_dvld_i      (rx_dvld_i),
    .rx_goodframe_i (rx_goodframe_i),
    .rx_badframe_i  (rx_badframe_i),
    .byte_full_i    (byte_full),
    .byte_push_o    (byte_push),
    .byte_data_o    (byte_data),
    .desc_full_i    (desc_full),
    .desc_push_o    (desc_push),
    .desc_data_o    (desc_data),
    .drop_count_o   (drop_count_o)
  );

  frame_fifo #(
    .payload_t (gbe_loopback_pkg::mac_byte_t),
    .DEPTH     (`GBE_BYTE_DEPTH)
  ) u_byte_fifo (
    .clk_125     (clk_125),
    .arst_n_i    (arst_n_i),
    .push_i      (byte_push),
    .push_data_i (byte_data),
    .full_o      (byte_full),
    .pop_i       (byte_pop),
    .head_o      (byte_head),
    .empty_o     (byte_empty)
  );

  frame_fifo #(
    .payload_t (gbe_loopback_pkg::frame_desc_t),
    .DEPTH     (`GBE_DESC_DEPTH)
  ) u_desc_fifo (
    .clk_125     (clk_125),
    .arst_n_i    (arst_n_i),
    .push_i      (desc_push),
    .push_data_i (desc_data),
    .full_o      (desc_full),
    .pop_i       (desc_pop),
    .head_o      (desc_head),
    .empty_o     (desc_empty)
  );

  tx_frame_reader u_reader (
    .clk_125      (clk_125),
    .arst_n_i     (arst_n_i),
    .desc_empty_i (desc_empty),
    .desc_head_i  (desc_head),
    .desc_pop_o   (desc_pop),
    .byte_empty_i (byte_empty),
    .byte_head_i  (byte_head),
    .byte_pop_o   (byte_pop),
    .tx_data_o    (tx_data_o),
    .tx_dvld_o    (tx_dvld_o),
    .tx_ack_i     (tx_ack_i)
  );

endmodule

`default_nettype wire

// ==== test/tb_gbe_loopback.sv ====
`include "gbe_loopback_settings.svh"

`default_nettype none

module tb_gbe_loopback;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int N_RAND      = 10;
  localparam int MAX_LEN     = 72;
  localparam int SHORT_LEN   = 6;
  localparam int GAP         = 12;
  // watchdog budget in cycles per byte and per frame
  localparam int MARGIN      = 4;
  localparam int OVERHEAD    = 32;
  localparam int N_FRAMES    = N_RAND + `GBE_DESC_DEPTH + 8;
  localparam int TOTAL_BYTES = (N_RAND + 4) * MAX_LEN + (`GBE_DESC_DEPTH + 3) * SHORT_LEN
                             + `GBE_BYTE_DEPTH + 20;

  logic                   clk_125;
  logic                   arst_n_i;
  logic [7:0]             rx_data_i;
  logic                   rx_dvld_i;
  logic                   rx_goodframe_i;
  logic                   rx_badframe_i;
  logic [7:0]             tx_data_o;
  logic                   tx_dvld_o;
  logic                   tx_ack_i;
  logic [`GBE_DROP_W-1:0] drop_count_o;

  logic [31:0] lfsr_q;
  logic [7:0]  exp_bytes[$];
  int          exp_lens[$];
  int          exp_drops;
  int          pending;
  int          value_errors;
  int          other_errors;
  logic        ack_on;
  logic        good_seen;
  logic        acked_q;
  logic        in_frame;
  int          frame_len;
  int          got_cnt;

  gbe_loopback uut (.*);

  initial begin
    clk_125 = 1'b0;
    forever #50 clk_125 = ~clk_125;
  end

  // taps of x^32 + x^22 + x^2 + x + 1 stepped once per bit
  function automatic logic [31:0] lfsr_bits(input int n);
    logic [31:0] r;
    logic        fb;
    int          k;
    r = '0;
    for (k = 0; k < n; k++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      r      = {r[30:0], fb};
    end
    return r;
  endfunction

  function automatic int random_len();
    return 8 + int'(lfsr_bits(6));
  endfunction

  task automatic report_value(input string msg);
    value_errors++;
    $display("[ERROR] t=%0d ns: %s", $time, msg);
  endtask

  task automatic report_other(input string msg);
    other_errors++;
    $display("failure: %s", msg);
  endtask

  task automatic next_cycle();
    @(posedge clk_125);
    #10;
  endtask

  // comes_out is the fate predicted by the writer rules
  task automatic send_frame(input int len, input bit good, input bit comes_out);
    logic [7:0] b;
    int         i;
    if (comes_out) begin
      exp_lens.push_back(len);
      pending++;
    end else begin
      exp_drops++;
    end
    for (i = 0; i < len; i++) begin
      b = 8'(lfsr_bits(8));
      if (comes_out) begin
        exp_bytes.push_back(b);
      end
      rx_data_i = b;
      rx_dvld_i = 1'b1;
      next_cycle();
    end
    rx_dvld_i = 1'b0;
    rx_data_i = 8'h00;
    // status sometimes trails the end of dvld
    if (lfsr_bits(1) != 0) begin
      next_cycle();
    end
    rx_goodframe_i = good;
    rx_badframe_i  = !good;
    if (good) begin
      good_seen = 1'b1;
    end
    next_cycle();
    rx_goodframe_i = 1'b0;
    rx_badframe_i  = 1'b0;
    repeat (GAP) next_cycle();
  endtask

  task automatic wait_drained();
    while (pending > 0) @(negedge clk_125);
    assert (int'(drop_count_o) == exp_drops)
      else report_value($sformatf("drop_count_o is %0d, expected %0d", drop_count_o, exp_drops));
    next_cycle();
  endtask

  always @(posedge clk_125 or negedge arst_n_i) begin
    if (!arst_n_i) begin
      acked_q <= 1'b0;
    end else begin
      acked_q <= tx_dvld_o && (acked_q || tx_ack_i);
    end
  end

  assert property (@(posedge clk_125) disable iff (!arst_n_i)
    !good_seen |-> (!tx_dvld_o && drop_count_o == '0))
    else report_value("tx active or drops counted before any good frame");

  // first byte held while the ack is outstanding
  assert property (@(posedge clk_125) disable iff (!arst_n_i)
    (tx_dvld_o && !acked_q && !tx_ack_i) |=> (tx_dvld_o && $stable(tx_data_o)))
    else report_value("tx_data_o or tx_dvld_o changed before the ack");

  assert property (@(posedge clk_125) disable iff (!arst_n_i)
    int'(drop_count_o) <= exp_drops)
    else report_value("drop_count_o counted a frame that was kept");

  initial begin : monitor
    forever begin
      @(negedge clk_125);
      if (arst_n_i) begin
        if (tx_dvld_o && tx_ack_i && !acked_q) begin
          in_frame  = 1'b1;
          got_cnt   = 0;
          frame_len = 0;
          if (exp_lens.size() == 0) begin
            report_other("a frame came out on tx that was never expected");
          end else begin
            frame_len = exp_lens.pop_front();
          end
        end
        if (in_frame && tx_dvld_o) begin
          if (got_cnt < frame_len) begin
            assert (tx_data_o == exp_bytes[0])
              else report_value($sformatf("tx byte %0d is %02h, expected %02h",
                                          got_cnt, tx_data_o, exp_bytes[0]));
            void'(exp_bytes.pop_front());
          end
          got_cnt++;
        end else if (in_frame) begin
          in_frame = 1'b0;
          pending--;
          assert (got_cnt == frame_len)
            else report_value($sformatf("tx frame had %0d bytes, expected %0d",
                                        got_cnt, frame_len));
        end
      end
    end
  end

  initial begin : ack_responder
    int gap;
    tx_ack_i = 1'b0;
    forever begin
      @(negedge clk_125);
      if (ack_on && tx_dvld_o) begin
        gap = 1 + int'(lfsr_bits(2));
        repeat (gap) @(posedge clk_125);
        #10 tx_ack_i = 1'b1;
        @(posedge clk_125);
        #10 tx_ack_i = 1'b0;
        while (tx_dvld_o) @(negedge clk_125);
      end
    end
  end

  initial begin : watchdog
    repeat (MARGIN * (TOTAL_BYTES + N_FRAMES * OVERHEAD)) @(posedge clk_125);
    $display("failure: the run did not finish before the watchdog limit");
    $display("value errors: %0d, other failures: %0d", value_errors, other_errors + 1);
    $display("ERRORS FOUND");
    $finish;
  end

  initial begin : stimulus
    int i;
    lfsr_q         = 32'd83618;
    arst_n_i       = 1'b0;
    rx_data_i      = 8'h00;
    rx_dvld_i      = 1'b0;
    rx_goodframe_i = 1'b0;
    rx_badframe_i  = 1'b0;
    ack_on         = 1'b0;
    good_seen      = 1'b0;
    in_frame       = 1'b0;
    exp_drops      = 0;
    pending        = 0;
    value_errors   = 0;
    other_errors   = 0;
    repeat (2) next_cycle();
    arst_n_i = 1'b1;
    repeat (4) next_cycle();

    ack_on = 1'b1;
    for (i = 0; i < N_RAND; i++) begin
      send_frame(random_len(), 1'b1, 1'b1);
    end
    wait_drained();

    // bad frame between two good ones
    send_frame(random_len(), 1'b1, 1'b1);
    send_frame(random_len(), 1'b0, 1'b0);
    send_frame(random_len(), 1'b1, 1'b1);
    wait_drained();

    // reader holds one descriptor and the descriptor FIFO fills behind it
    ack_on = 1'b0;
    for (i = 0; i < `GBE_DESC_DEPTH + 3; i++) begin
      send_frame(SHORT_LEN, 1'b1, i < `GBE_DESC_DEPTH + 1);
    end
    ack_on = 1'b1;
    wait_drained();

    // oversize frame overflows the empty byte FIFO
    ack_on = 1'b0;
    send_frame(`GBE_BYTE_DEPTH + 20, 1'b1, 1'b0);
    ack_on = 1'b1;
    send_frame(random_len(), 1'b1, 1'b1);
    wait_drained();

    $display("value errors: %0d, other failures: %0d", value_errors, other_errors);
    if (value_errors + other_errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== all.f ====
+incdir+src
src/gbe_loopback_pkg.sv
src/frame_fifo.sv
src/rx_frame_writer.sv
src/tx_frame_reader.sv
src/gbe_loopback.sv
test/tb_gbe_loopback.sv

// ==== Makefile ====
TOP             ?= tb_gbe_loopback
LOG             ?= sim.log
BUILD_DIR       ?= build
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= -O3

.PHONY: simulate clean

# the run passes only if the log holds the pass line
simulate:
	$(VERILATOR) --binary --timing --assert $(VERILATOR_FLAGS) \
	  --top-module $(TOP) -Mdir $(BUILD_DIR) -f all.f
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^NO ERRORS$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
